//--- common/l2_pkg.sv
`default_nettype none

package l2_pkg;

    localparam int ADDR_BITS   = 16;
    localparam int LINE_BITS   = 128;
    localparam int BE_BITS     = LINE_BITS / 8;
    localparam int TAG_BITS    = 8;
    localparam int WORD_BITS   = 32;
    localparam int CHAN_DELAY  = 6;
    localparam int QUEUE_DEPTH = 4;
    localparam int STORE_LINES = 64;
    localparam int TIME_BITS   = 16;

    // Derived widths
    localparam int QPTR_BITS      = $clog2(QUEUE_DEPTH);
    localparam int WORD_SEL_BITS  = $clog2(LINE_BITS / WORD_BITS); // Words within a line
    localparam int STORE_IDX_BITS = $clog2(STORE_LINES);

    typedef enum logic [1:0] {
        CMD_READ   = 2'd0,
        CMD_WRITE  = 2'd1,
        CMD_ATOMIC = 2'd2
    } mem_cmd_e;

    typedef enum logic [3:0] {
        AMO_ADD  = 4'd0,
        AMO_AND  = 4'd1,
        AMO_OR   = 4'd2,
        AMO_SWAP = 4'd8,
        AMO_STEX = 4'd13 // Always succeeds, acked as a plain write
    } amo_op_e;

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [TAG_BITS-1:0]  tag;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [TAG_BITS-1:0]  tag;
        mem_cmd_e             cmd;
        amo_op_e              amo_op;
        logic [LINE_BITS-1:0] data;
        logic [BE_BITS-1:0]   be;
    } wr_req_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [LINE_BITS-1:0] data;     // Line for reads, old line for atomics
        logic                 is_atomic;
    } chan_rsp_t;

endpackage

`default_nettype wire

//--- mem_channel/mem_channel.sv
`timescale 1ns/10ps
`default_nettype none

module mem_channel #(
    parameter type req_t = l2_pkg::rd_req_t
) (
    input  wire logic          clk_i,
    input  wire logic          rstn_i,

    input  wire logic          req_valid_i,
    input  wire req_t          req_i,
    output logic               req_ready_o,

    output logic               exec_o,
    output req_t               head_o,
    input  wire l2_pkg::chan_rsp_t exec_rsp_i,

    output logic               rsp_valid_o,
    output l2_pkg::chan_rsp_t  rsp_o,
    input  wire logic          rsp_ready_i
);

    typedef struct packed {
        req_t                         req;
        logic [l2_pkg::TIME_BITS-1:0] stamp;
    } entry_t;

    typedef enum logic [1:0] {
        S_WAIT,
        S_EXEC,
        S_HOLD
    } state_t;

    logic [l2_pkg::TIME_BITS-1:0] cycles;
    logic [l2_pkg::TIME_BITS-1:0] head_age;

    entry_t                       queue [l2_pkg::QUEUE_DEPTH];
    entry_t                       head;
    logic [l2_pkg::QPTR_BITS-1:0] wr_ptr, rd_ptr;
    logic [l2_pkg::QPTR_BITS:0]   count;  // One extra bit so full fits
    logic                         empty, full, push, pop;

    state_t                       state;
    l2_pkg::chan_rsp_t            rsp_q;

    // Free running cycle count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 1'b1;
        end
    end

    assign empty = (count == '0);
    assign full  = (count == l2_pkg::QUEUE_DEPTH);
    assign push  = req_valid_i && !full;
    assign pop   = (state == S_EXEC);
    assign head  = queue[rd_ptr];

    // Stamp is the count seen once the entry sits in the queue
    always_ff @(posedge clk_i) begin
        if (push) begin
            queue[wr_ptr].req   <= req_i;
            queue[wr_ptr].stamp <= cycles + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_age = cycles - head.stamp; // Wraps cleanly

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state <= S_WAIT;
        end else begin
            case (state)
                S_WAIT: if (!empty && head_age >= l2_pkg::CHAN_DELAY) state <= S_EXEC;
                S_EXEC: state <= S_HOLD;
                S_HOLD: if (rsp_ready_i) state <= S_WAIT;
                default: state <= S_WAIT;
            endcase
        end
    end

    // Store answers in the exec cycle
    always_ff @(posedge clk_i) begin
        if (state == S_EXEC) rsp_q <= exec_rsp_i;
    end

    assign req_ready_o = !full;
    assign exec_o      = (state == S_EXEC);
    assign head_o      = head.req;
    assign rsp_valid_o = (state == S_HOLD);
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module l2_uncached_tb -o l2_uncached_sim

./obj_dir/l2_uncached_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Test passed" sim.log
echo "Simulation passed"

//--- source/l2_uncached_top.sv
`timescale 1ns/10ps
`default_nettype none

module l2_uncached_top (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    input  wire logic              rd_req_valid_i,
    input  wire l2_pkg::rd_req_t   rd_req_i,
    output logic                   rd_req_ready_o,

    input  wire logic              wr_req_valid_i,
    input  wire l2_pkg::wr_req_t   wr_req_i,
    output logic                   wr_req_ready_o,

    output logic                   rd_rsp_valid_o,
    output l2_pkg::chan_rsp_t      rd_rsp_o,
    input  wire logic              rd_rsp_ready_i,

    output logic                   wr_rsp_valid_o,
    output l2_pkg::chan_rsp_t      wr_rsp_o,
    input  wire logic              wr_rsp_ready_i
);

    logic              rd_exec, wr_exec;
    l2_pkg::rd_req_t   rd_head;
    l2_pkg::wr_req_t   wr_head;
    l2_pkg::chan_rsp_t rd_exec_rsp, wr_exec_rsp;

    logic              rd_chan_valid, rd_chan_ready;
    logic              wr_chan_valid, wr_chan_ready;
    l2_pkg::chan_rsp_t rd_chan_rsp, wr_chan_rsp;

    // Uncached read port, whole lines
    mem_channel #(.req_t(l2_pkg::rd_req_t)) rd_channel (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (rd_req_valid_i),
        .req_i       (rd_req_i),
        .req_ready_o (rd_req_ready_o),
        .exec_o      (rd_exec),
        .head_o      (rd_head),
        .exec_rsp_i  (rd_exec_rsp),
        .rsp_valid_o (rd_chan_valid),
        .rsp_o       (rd_chan_rsp),
        .rsp_ready_i (rd_chan_ready)
    );

    // Uncached write port, writes and atomics
    mem_channel #(.req_t(l2_pkg::wr_req_t)) wr_channel (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (wr_req_valid_i),
        .req_i       (wr_req_i),
        .req_ready_o (wr_req_ready_o),
        .exec_o      (wr_exec),
        .head_o      (wr_head),
        .exec_rsp_i  (wr_exec_rsp),
        .rsp_valid_o (wr_chan_valid),
        .rsp_o       (wr_chan_rsp),
        .rsp_ready_i (wr_chan_ready)
    );

    line_store line_store_inst (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rd_exec_i (rd_exec),
        .rd_head_i (rd_head),
        .rd_rsp_o  (rd_exec_rsp),
        .wr_exec_i (wr_exec),
        .wr_head_i (wr_head),
        .wr_rsp_o  (wr_exec_rsp)
    );

    uc_resp_merge uc_resp_merge_inst (
        .rd_valid_i     (rd_chan_valid),
        .rd_rsp_i       (rd_chan_rsp),
        .rd_ready_o     (rd_chan_ready),
        .wr_valid_i     (wr_chan_valid),
        .wr_rsp_i       (wr_chan_rsp),
        .wr_ready_o     (wr_chan_ready),
        .rd_rsp_valid_o (rd_rsp_valid_o),
        .rd_rsp_o       (rd_rsp_o),
        .rd_rsp_ready_i (rd_rsp_ready_i),
        .wr_rsp_valid_o (wr_rsp_valid_o),
        .wr_rsp_o       (wr_rsp_o),
        .wr_rsp_ready_i (wr_rsp_ready_i)
    );

endmodule

`default_nettype wire

//--- source/line_store.sv
`timescale 1ns/10ps
`default_nettype none

module line_store (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    input  wire logic              rd_exec_i,
    input  wire l2_pkg::rd_req_t   rd_head_i,
    output l2_pkg::chan_rsp_t      rd_rsp_o,

    input  wire logic              wr_exec_i,
    input  wire l2_pkg::wr_req_t   wr_head_i,
    output l2_pkg::chan_rsp_t      wr_rsp_o
);

    logic [l2_pkg::LINE_BITS-1:0]      lines [l2_pkg::STORE_LINES];

    logic [l2_pkg::STORE_IDX_BITS-1:0] rd_idx, wr_idx;
    logic [l2_pkg::WORD_SEL_BITS-1:0]  wr_sel;
    logic [l2_pkg::LINE_BITS-1:0]      old_line, merge_line, amo_line, next_line;
    logic [l2_pkg::WORD_BITS-1:0]      old_word, opnd, new_word;
    logic                              wr_wen;

    // Low address bits pick the word, the rest the line
    assign rd_idx = rd_head_i.addr[l2_pkg::STORE_IDX_BITS+l2_pkg::WORD_SEL_BITS-1:
                                   l2_pkg::WORD_SEL_BITS];
    assign wr_idx = wr_head_i.addr[l2_pkg::STORE_IDX_BITS+l2_pkg::WORD_SEL_BITS-1:
                                   l2_pkg::WORD_SEL_BITS];
    assign wr_sel = wr_head_i.addr[l2_pkg::WORD_SEL_BITS-1:0];

    always_comb begin
        rd_rsp_o.tag       = rd_head_i.tag;
        rd_rsp_o.data      = rd_exec_i ? lines[rd_idx] : '0; // Quiet when idle
        rd_rsp_o.is_atomic = 1'b0;
    end

    always_comb begin
        old_line = lines[wr_idx];
        old_word = old_line[wr_sel*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS];
        opnd     = wr_head_i.data[wr_sel*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS];

        case (wr_head_i.amo_op)
            l2_pkg::AMO_SWAP, l2_pkg::AMO_STEX: new_word = opnd;
            l2_pkg::AMO_ADD: new_word = old_word + opnd;
            l2_pkg::AMO_AND: new_word = old_word & opnd;
            l2_pkg::AMO_OR:  new_word = old_word | opnd;
            default:         new_word = old_word;
        endcase

        amo_line = old_line;
        amo_line[wr_sel*l2_pkg::WORD_BITS +: l2_pkg::WORD_BITS] = new_word;

        for (int b = 0; b < l2_pkg::BE_BITS; b++) begin
            merge_line[b*8 +: 8] = wr_head_i.be[b] ? wr_head_i.data[b*8 +: 8] : old_line[b*8 +: 8];
        end

        wr_wen             = 1'b0;
        next_line          = old_line;
        wr_rsp_o.tag       = wr_head_i.tag;
        wr_rsp_o.data      = '0;
        wr_rsp_o.is_atomic = 1'b0;

        case (wr_head_i.cmd)
            l2_pkg::CMD_WRITE: begin
                wr_wen    = 1'b1;
                next_line = merge_line;
            end
            l2_pkg::CMD_ATOMIC: begin
                wr_wen    = 1'b1;
                next_line = amo_line;
                if (wr_head_i.amo_op != l2_pkg::AMO_STEX) begin
                    wr_rsp_o.data      = old_line;
                    wr_rsp_o.is_atomic = 1'b1;
                end
            end
            default: wr_rsp_o.data = old_line; // Read on the write port
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < l2_pkg::STORE_LINES; i++) begin
                lines[i] <= '0;
            end
        end else if (wr_exec_i && wr_wen) begin
            lines[wr_idx] <= next_line;
        end
    end

endmodule

`default_nettype wire

//--- source/uc_resp_merge.sv
`timescale 1ns/10ps
`default_nettype none

module uc_resp_merge (
    input  wire logic              rd_valid_i,
    input  wire l2_pkg::chan_rsp_t rd_rsp_i,
    output logic                   rd_ready_o,

    input  wire logic              wr_valid_i,
    input  wire l2_pkg::chan_rsp_t wr_rsp_i,
    output logic                   wr_ready_o,

    output logic                   rd_rsp_valid_o,
    output l2_pkg::chan_rsp_t      rd_rsp_o,
    input  wire logic              rd_rsp_ready_i,

    output logic                   wr_rsp_valid_o,
    output l2_pkg::chan_rsp_t      wr_rsp_o,
    input  wire logic              wr_rsp_ready_i
);

    always_comb begin
        rd_rsp_valid_o = 1'b0;
        rd_rsp_o       = '0;
        rd_ready_o     = 1'b0;
        wr_rsp_valid_o = 1'b0;
        wr_rsp_o       = '0;
        wr_ready_o     = 1'b0;

        // Read data owns the read port
        if (rd_valid_i) begin
            rd_rsp_valid_o = 1'b1;
            rd_rsp_o       = rd_rsp_i;
            rd_ready_o     = rd_rsp_ready_i;
        end

        if (wr_valid_i) begin
            if (wr_rsp_i.is_atomic) begin
                // Atomic needs both ports at once
                if (!rd_valid_i) begin
                    rd_rsp_valid_o = 1'b1;
                    rd_rsp_o       = wr_rsp_i;
                    wr_rsp_valid_o = 1'b1;
                    wr_rsp_o       = wr_rsp_i;
                    wr_ready_o     = wr_rsp_ready_i;
                end
            end else begin
                wr_rsp_valid_o = 1'b1; // Plain ack or STEX
                wr_rsp_o       = wr_rsp_i;
                wr_ready_o     = wr_rsp_ready_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verification
common/l2_pkg.sv
mem_channel/mem_channel.sv
source/line_store.sv
source/uc_resp_merge.sv
source/l2_uncached_top.sv
verification/tb_clock.sv
verification/l2_uncached_tb.sv

//--- verification/l2_uncached_tests.svh
`ifndef L2_UNCACHED_TESTS_SVH
`define L2_UNCACHED_TESTS_SVH

    // Addresses stay below 256, so no two lines alias
    function automatic int line_of(input logic [15:0] addr);
        return int'(addr[7:2]);
    endfunction

    function automatic logic [31:0] amo_expect(input l2_pkg::amo_op_e op,
                                               input logic [31:0] old_w,
                                               input logic [31:0] opnd);
        case (op)
            l2_pkg::AMO_ADD: return old_w + opnd;
            l2_pkg::AMO_AND: return old_w & opnd;
            l2_pkg::AMO_OR:  return old_w | opnd;
            default:         return opnd; // Swap
        endcase
    endfunction

    // Plain write or store-conditional, both acked on the write port only
    task automatic write_line(input l2_pkg::wr_req_t wq);
        l2_pkg::chan_rsp_t rsp, rd_side;
        logic              rd_side_valid, rd_early;
        int                idx;
        int                w;
        idx = line_of(wq.addr);
        w   = int'(wq.addr[1:0]);
        send_wr(wq);
        wait_wr_rsp(rsp, rd_side, rd_side_valid, rd_early);
        check_val("wr_rsp.tag", rsp.tag, wq.tag);
        check_val("wr_rsp.data", rsp.data, 128'd0);
        check_val("wr_rsp.is_atomic", rsp.is_atomic, 1'b0);
        check_true(!rd_side_valid && !rd_early, "write gave a read-port response");
        if (wq.cmd == l2_pkg::CMD_WRITE) begin
            for (int b = 0; b < l2_pkg::BE_BITS; b++) begin
                if (wq.be[b]) begin
                    model_mem[idx][b*8 +: 8] = wq.data[b*8 +: 8];
                end
            end
        end else begin
            model_mem[idx][w*32 +: 32] = wq.data[w*32 +: 32];
        end
    endtask

    task automatic read_line(input logic [15:0] addr, input logic [7:0] tag,
                             input logic check_lat);
        l2_pkg::rd_req_t   rq;
        l2_pkg::chan_rsp_t rsp;
        int                lat;
        rq.addr = addr;
        rq.tag  = tag;
        send_rd(rq);
        wait_rd_rsp(rsp, lat);
        check_val("rd_rsp.tag", rsp.tag, tag);
        check_val("rd_rsp.data", rsp.data, model_mem[line_of(addr)]);
        check_val("rd_rsp.is_atomic", rsp.is_atomic, 1'b0);
        if (check_lat) begin
            check_val("read latency", lat, l2_pkg::CHAN_DELAY + 2);
        end
    endtask

    task automatic reset_values();
        int errs;
        errs = errors;
        check_val("rd_req_ready_o", rd_req_ready, 1'b1);
        check_val("wr_req_ready_o", wr_req_ready, 1'b1);
        check_val("rd_rsp_valid_o", rd_rsp_valid, 1'b0);
        check_val("wr_rsp_valid_o", wr_rsp_valid, 1'b0);
        report_test("reset_values", errs);
    endtask

    task automatic write_then_read();
        l2_pkg::wr_req_t wq;
        logic [127:0]    r;
        int              errs;
        errs    = errors;
        r       = rand_bits(16);
        wq      = '0;
        wq.addr = 16'h0014; // Line 5
        wq.tag  = 8'h11;
        wq.cmd  = l2_pkg::CMD_WRITE;
        wq.data = rand_bits(128);
        wq.be   = r[15:0];
        write_line(wq);
        read_line(16'h0014, 8'h12, 1'b1);
        report_test("write_then_read", errs);
    endtask

    task automatic atomic_ops();
        l2_pkg::wr_req_t   wq;
        l2_pkg::chan_rsp_t rsp, rd_side;
        logic              rd_side_valid, rd_early;
        logic [127:0]      old_line;
        l2_pkg::amo_op_e   ops [4];
        int                idx;
        int                errs;
        errs    = errors;
        ops     = '{l2_pkg::AMO_ADD, l2_pkg::AMO_SWAP, l2_pkg::AMO_AND, l2_pkg::AMO_OR};
        wq      = '0;
        wq.addr = 16'h0025; // Line 9, word 1
        wq.tag  = 8'h20;
        wq.cmd  = l2_pkg::CMD_WRITE;
        wq.data = rand_bits(128);
        wq.be   = '1;
        write_line(wq);
        idx = line_of(wq.addr);
        for (int i = 0; i < 4; i++) begin
            old_line  = model_mem[idx];
            wq.tag    = 8'h21 + 8'(i);
            wq.cmd    = l2_pkg::CMD_ATOMIC;
            wq.amo_op = ops[i];
            wq.data   = rand_bits(128); // Operand in word 1, noise around it
            wq.be     = '0;
            send_wr(wq);
            wait_wr_rsp(rsp, rd_side, rd_side_valid, rd_early);
            check_true(rd_side_valid && !rd_early, "atomic result not on both ports at once");
            check_val("rd_rsp.tag", rd_side.tag, wq.tag);
            check_val("rd_rsp.data", rd_side.data, old_line);
            check_val("wr_rsp.tag", rsp.tag, wq.tag);
            check_val("wr_rsp.data", rsp.data, old_line);
            check_val("wr_rsp.is_atomic", rsp.is_atomic, 1'b1);
            model_mem[idx][32 +: 32] = amo_expect(ops[i], old_line[32 +: 32], wq.data[32 +: 32]);
        end
        read_line(16'h0025, 8'h2f, 1'b1);
        report_test("atomic_ops", errs);
    endtask

    task automatic store_conditional();
        l2_pkg::wr_req_t wq;
        int              errs;
        errs    = errors;
        wq      = '0;
        wq.addr = 16'h0032; // Line 12, word 2
        wq.tag  = 8'h30;
        wq.cmd  = l2_pkg::CMD_WRITE;
        wq.data = rand_bits(128);
        wq.be   = '1;
        write_line(wq);
        wq.tag    = 8'h31;
        wq.cmd    = l2_pkg::CMD_ATOMIC;
        wq.amo_op = l2_pkg::AMO_STEX;
        wq.data   = rand_bits(128);
        wq.be     = '0;
        write_line(wq);
        read_line(16'h0032, 8'h32, 1'b1);
        report_test("store_conditional", errs);
    endtask

    task automatic read_backpressure();
        l2_pkg::wr_req_t   wq;
        l2_pkg::rd_req_t   rq;
        l2_pkg::chan_rsp_t rsp, held;
        logic [15:0]       addrs [$];
        int                n, lat;
        int                errs;
        errs = errors;
        for (int i = 0; i < l2_pkg::QUEUE_DEPTH + 2; i++) begin
            wq      = '0;
            wq.addr = 16'h0040 + 16'(i * 4);
            wq.tag  = 8'h50 + 8'(i);
            wq.cmd  = l2_pkg::CMD_WRITE;
            wq.data = rand_bits(128);
            wq.be   = '1;
            write_line(wq);
        end
        rd_rsp_ready = 1'b0;
        n            = 0;
        while (rd_req_ready && n < l2_pkg::QUEUE_DEPTH + 2) begin
            rq.addr      = 16'h0040 + 16'(n * 4);
            rq.tag       = 8'h60 + 8'(n);
            rd_req       = rq;
            rd_req_valid = 1'b1;
            addrs.push_back(rq.addr);
            step();
            n++;
        end
        rd_req_valid = 1'b0;
        check_true(!rd_req_ready, "read request ready never dropped under back-pressure");
        lat = 0;
        while (!rd_rsp_valid && lat < TIMEOUT) begin
            step();
            lat++;
        end
        check_true(rd_rsp_valid, "timeout waiting for a held read response");
        held = rd_rsp;
        repeat (3) begin
            step();
            check_true(rd_rsp_valid, "read response dropped while held");
            check_val("rd_rsp.tag", rd_rsp.tag, held.tag);
            check_val("rd_rsp.data", rd_rsp.data, held.data);
        end
        rd_rsp_ready = 1'b1;
        foreach (addrs[i]) begin
            wait_rd_rsp(rsp, lat);
            check_val("rd_rsp.tag", rsp.tag, 8'h60 + 8'(i));
            check_val("rd_rsp.data", rsp.data, model_mem[line_of(addrs[i])]);
        end
        report_test("read_backpressure", errs);
    endtask

`endif

//--- verification/l2_uncached_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l2_uncached_tb;

    localparam int TIMEOUT = 100;

    logic              clk, rstn;
    logic              rd_req_valid, rd_req_ready;
    l2_pkg::rd_req_t   rd_req;
    logic              wr_req_valid, wr_req_ready;
    l2_pkg::wr_req_t   wr_req;
    logic              rd_rsp_valid, rd_rsp_ready;
    l2_pkg::chan_rsp_t rd_rsp;
    logic              wr_rsp_valid, wr_rsp_ready;
    l2_pkg::chan_rsp_t wr_rsp;

    logic [15:0]       lfsr_q;
    logic [127:0]      model_mem [l2_pkg::STORE_LINES]; // Expected line contents
    int                checks;
    int                errors;

    tb_clock tb_clock_inst (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    l2_uncached_top l2_uncached_top_inst (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .rd_req_valid_i (rd_req_valid),
        .rd_req_i       (rd_req),
        .rd_req_ready_o (rd_req_ready),
        .wr_req_valid_i (wr_req_valid),
        .wr_req_i       (wr_req),
        .wr_req_ready_o (wr_req_ready),
        .rd_rsp_valid_o (rd_rsp_valid),
        .rd_rsp_o       (rd_rsp),
        .rd_rsp_ready_i (rd_rsp_ready),
        .wr_rsp_valid_o (wr_rsp_valid),
        .wr_rsp_o       (wr_rsp),
        .wr_rsp_ready_i (wr_rsp_ready)
    );

    // Inputs change and outputs are sampled 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        logic         fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[126:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 'h%0h, expected 'h%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("[%s] finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic send_rd(input l2_pkg::rd_req_t req);
        int n;
        n            = 0;
        rd_req       = req;
        rd_req_valid = 1'b1;
        while (!rd_req_ready && n < TIMEOUT) begin
            step();
            n++;
        end
        check_true(rd_req_ready, "read request never accepted");
        step();
        rd_req_valid = 1'b0;
    endtask

    task automatic send_wr(input l2_pkg::wr_req_t req);
        int n;
        n            = 0;
        wr_req       = req;
        wr_req_valid = 1'b1;
        while (!wr_req_ready && n < TIMEOUT) begin
            step();
            n++;
        end
        check_true(wr_req_ready, "write request never accepted");
        step();
        wr_req_valid = 1'b0;
    endtask

    // Latency counts edges from acceptance to response valid
    task automatic wait_rd_rsp(output l2_pkg::chan_rsp_t rsp, output int lat);
        lat = 0;
        while (!rd_rsp_valid && lat < TIMEOUT) begin
            step();
            lat++;
        end
        check_true(rd_rsp_valid, "timeout waiting for a read response");
        rsp = rd_rsp;
        step();
    endtask

    task automatic wait_wr_rsp(output l2_pkg::chan_rsp_t rsp, output l2_pkg::chan_rsp_t rd_side,
                               output logic rd_side_valid, output logic rd_early);
        int n;
        n        = 0;
        rd_early = 1'b0;
        while (!wr_rsp_valid && n < TIMEOUT) begin
            rd_early = rd_early | rd_rsp_valid;
            step();
            n++;
        end
        check_true(wr_rsp_valid, "timeout waiting for a write response");
        rsp           = wr_rsp;
        rd_side       = rd_rsp;
        rd_side_valid = rd_rsp_valid;
        step();
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (!rstn && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_true(rstn, "reset never released");
        step();
    endtask

    `include "l2_uncached_tests.svh"

    initial begin
        rd_req_valid = 1'b0;
        rd_req       = '0;
        wr_req_valid = 1'b0;
        wr_req       = '0;
        rd_rsp_ready = 1'b1;
        wr_rsp_ready = 1'b1;
        lfsr_q       = 16'd79;
        checks       = 0;
        errors       = 0;
        for (int i = 0; i < l2_pkg::STORE_LINES; i++) begin
            model_mem[i] = '0;
        end
        wait_reset();
        reset_values();
        write_then_read();
        atomic_ops();
        store_conditional();
        read_backpressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        rstn_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #2 rstn_o = 1'b1; // Released off the edge
    end

endmodule

`default_nettype wire
